//--- common/if_pkg.sv
////////////////////
// fetch stage package
// shared constants, selector enums and bundles of the
// instruction fetch stage
////////////////////

`default_nettype none

package if_pkg;

  ////////////////////
  // constants
  ////////////////////

  // address and instruction width
  localparam int unsigned XLEN           = 32;
  // first fetch sits this far above the boot base
  localparam logic [7:0]  BOOT_OFFSET    = 8'h80;
  // low bits cleared from boot address and mtvec
  localparam int unsigned VEC_ALIGN_BITS = 8;
  // debug module entry points
  localparam logic [XLEN-1:0] DM_HALT_ADDR = 32'h1A11_0800;
  localparam logic [XLEN-1:0] DM_EXC_ADDR  = 32'h1A11_0808;
  // all internal interrupts share the nmi slot
  localparam logic [4:0]  IRQ_NM_CAUSE   = 5'd31;
  // buffered words plus live requests on the bus
  localparam int unsigned FETCH_DEPTH    = 2;

  ////////////////////
  // selectors
  ////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // which exception vector to take
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  ////////////////////
  // bundles
  ////////////////////

  typedef struct packed {
    logic       irq_ext;
    logic       irq_int;
    logic [4:0] lower_cause;
  } exc_cause_t;

  // csr values that can become a fetch target
  typedef struct packed {
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] depc;
    logic [XLEN-1:0] mtvec;
  } csr_pc_t;

  // one slot of the prefetch queue
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] rdata;
    logic            err;
  } fetch_entry_t;

  // contents of the if-id register
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] pc;
    logic            fetch_err;
  } id_instr_t;

endpackage

`default_nettype wire

//--- src/pc_select.sv
////////////////////
// pc select
// next fetch address and exception vector muxes,
// mtvec init strobe on boot
////////////////////

`default_nettype none

module pc_select (
  input  wire logic                         pc_set_i,
  input  wire if_pkg::pc_sel_e              pc_mux_i,
  input  wire if_pkg::exc_pc_sel_e          exc_pc_mux_i,
  input  wire if_pkg::exc_cause_t           exc_cause_i,
  input  wire logic [if_pkg::XLEN-1:0]      boot_addr_i,
  input  wire logic [if_pkg::XLEN-1:0]      branch_target_ex_i,
  input  wire if_pkg::csr_pc_t              csr_pc_i,
  output logic                              branch_o,
  output logic [if_pkg::XLEN-1:0]           branch_addr_o,
  output logic                              csr_mtvec_init_o
);

  logic [if_pkg::XLEN-1:0] vec_base;
  logic [if_pkg::XLEN-1:0] boot_pc;
  logic [4:0]              irq_vec;
  logic [if_pkg::XLEN-1:0] exc_pc;
  logic [if_pkg::XLEN-1:0] fetch_addr_n;

  // trap base, low byte forced to zero
  assign vec_base = {csr_pc_i.mtvec[if_pkg::XLEN-1:if_pkg::VEC_ALIGN_BITS],
                     {if_pkg::VEC_ALIGN_BITS{1'b0}}};

  // boot entry is the aligned boot base plus fixed offset
  assign boot_pc = {boot_addr_i[if_pkg::XLEN-1:if_pkg::VEC_ALIGN_BITS],
                    {if_pkg::VEC_ALIGN_BITS{1'b0}}} + if_pkg::XLEN'(if_pkg::BOOT_OFFSET);

  // internal interrupts are routed to the nmi slot
  assign irq_vec = exc_cause_i.irq_int ? if_pkg::IRQ_NM_CAUSE : exc_cause_i.lower_cause;

  ////////////////////
  // exception vector
  ////////////////////
  always_comb begin
    unique case (exc_pc_mux_i)
      if_pkg::EXC_PC_EXC:     exc_pc = vec_base;
      // vectored mode, one word per cause
      if_pkg::EXC_PC_IRQ:     exc_pc = vec_base + {{(if_pkg::XLEN-7){1'b0}}, irq_vec, 2'b00};
      if_pkg::EXC_PC_DBD:     exc_pc = if_pkg::DM_HALT_ADDR;
      if_pkg::EXC_PC_DBG_EXC: exc_pc = if_pkg::DM_EXC_ADDR;
      default:                exc_pc = vec_base;
    endcase
  end

  ////////////////////
  // fetch target
  ////////////////////
  always_comb begin
    unique case (pc_mux_i)
      if_pkg::PC_BOOT: fetch_addr_n = boot_pc;
      if_pkg::PC_JUMP: fetch_addr_n = branch_target_ex_i;
      if_pkg::PC_EXC:  fetch_addr_n = exc_pc;
      // return from trap
      if_pkg::PC_ERET: fetch_addr_n = csr_pc_i.mepc;
      // return from debug mode
      if_pkg::PC_DRET: fetch_addr_n = csr_pc_i.depc;
      default:         fetch_addr_n = boot_pc;
    endcase
  end

  // every instruction is a full word
  assign branch_addr_o = {fetch_addr_n[if_pkg::XLEN-1:2], 2'b00};
  assign branch_o      = pc_set_i;

  // csr file loads its mtvec reset value on boot
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_pkg::PC_BOOT);

endmodule

`default_nettype wire

//--- prefetch/fetch_fifo.sv
////////////////////
// fetch fifo
// two-slot circular queue of fetched words, their addresses
// and bus error flags, emptied on a flush
////////////////////

`default_nettype none

module fetch_fifo (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 flush_i,
  input  wire logic                 push_i,
  input  wire if_pkg::fetch_entry_t push_entry_i,
  input  wire logic                 pop_i,
  output logic                      valid_o,
  output if_pkg::fetch_entry_t      head_o,
  output logic [1:0]                count_o
);

  // storage, no reset on payload
  if_pkg::fetch_entry_t mem [if_pkg::FETCH_DEPTH];

  // one bit pointers wrap on their own for two slots
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push_ok;

  // push during a flush belongs to the old stream
  assign push_ok = push_i & ~flush_i;

  ////////////////////
  // pointers and fill level
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else if (flush_i) begin
      // drop everything, restart from slot zero
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leave the level unchanged
      case ({push_ok, pop_i})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  ////////////////////
  // data slots
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= push_entry_i;
    end
  end

  // head is visible the cycle after its push
  assign valid_o = (count_q != 2'd0);
  assign head_o  = mem[rd_ptr_q];
  assign count_o = count_q;

endmodule

`default_nettype wire

//--- prefetch/prefetch_ctrl.sv
////////////////////
// prefetch control
// issues word requests on the instruction bus, tracks live
// and stale responses, pushes fetched words to the fifo
////////////////////

`default_nettype none

module prefetch_ctrl (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    req_i,
  input  wire logic                    branch_i,
  input  wire logic [if_pkg::XLEN-1:0] branch_addr_i,
  input  wire logic                    instr_gnt_i,
  input  wire logic                    instr_rvalid_i,
  input  wire logic [if_pkg::XLEN-1:0] instr_rdata_i,
  input  wire logic                    instr_bus_err_i,
  input  wire logic [1:0]              fifo_count_i,
  output logic                         instr_req_o,
  output logic [if_pkg::XLEN-1:0]      instr_addr_o,
  output logic                         push_o,
  output if_pkg::fetch_entry_t         push_entry_o,
  output logic                         busy_o
);

  // address of the next request and of the next live response
  logic [if_pkg::XLEN-1:0] req_addr_q;
  logic [if_pkg::XLEN-1:0] rsp_addr_q;

  // granted requests of the current stream
  logic [1:0] live_q;
  logic [1:0] live_d;
  // granted requests left over from a flushed stream
  logic [2:0] stale_q;
  logic [2:0] stale_d;

  logic [2:0] occupancy;
  logic       room;
  logic       gnt_fire;
  logic       rsp_live;
  logic       rsp_stale;

  ////////////////////
  // request side
  ////////////////////

  // words waiting in the fifo plus words still coming back
  assign occupancy = {1'b0, fifo_count_i} + {1'b0, live_q};
  // also back off when the stale backlog gets deep
  assign room      = (occupancy < 3'(if_pkg::FETCH_DEPTH)) & ~stale_q[2];

  assign instr_req_o  = req_i & room;
  assign instr_addr_o = req_addr_q;
  assign gnt_fire     = instr_req_o & instr_gnt_i;

  ////////////////////
  // response side
  ////////////////////

  // responses return in order, so stale ones come first
  assign rsp_stale = instr_rvalid_i & (stale_q != 3'd0);
  assign rsp_live  = instr_rvalid_i & (stale_q == 3'd0);

  assign push_o             = rsp_live;
  assign push_entry_o.addr  = rsp_addr_q;
  assign push_entry_o.rdata = instr_rdata_i;
  assign push_entry_o.err   = instr_bus_err_i;

  // outstanding counters
  always_comb begin
    live_d  = live_q + {1'b0, gnt_fire} - {1'b0, rsp_live};
    stale_d = stale_q - {2'b00, rsp_stale};
    if (branch_i) begin
      // everything granted so far now belongs to the old stream
      stale_d = stale_d + {1'b0, live_d};
      live_d  = 2'd0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      live_q  <= 2'd0;
      stale_q <= 3'd0;
    end else begin
      live_q  <= live_d;
      stale_q <= stale_d;
    end
  end

  ////////////////////
  // address counters
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_addr_q <= '0;
      rsp_addr_q <= '0;
    end else if (branch_i) begin
      // a redirect also replaces a request not yet granted
      req_addr_q <= branch_addr_i;
      rsp_addr_q <= branch_addr_i;
    end else begin
      if (gnt_fire) begin
        req_addr_q <= req_addr_q + if_pkg::XLEN'(4);
      end
      if (rsp_live) begin
        rsp_addr_q <= rsp_addr_q + if_pkg::XLEN'(4);
      end
    end
  end

  // busy while anything is on the bus or waiting for a grant
  assign busy_o = instr_req_o | (live_q != 2'd0) | (stale_q != 3'd0);

endmodule

`default_nettype wire

//--- src/if_id_regs.sv
////////////////////
// if-id register
// loads the fifo head into the decode stage, merges bus
// and pmp errors, keeps the valid and new flags
////////////////////

`default_nettype none

module if_id_regs (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 fetch_valid_i,
  input  wire if_pkg::fetch_entry_t fetch_entry_i,
  input  wire logic                 pmp_err_if_i,
  input  wire logic                 pc_set_i,
  input  wire logic                 instr_valid_clear_i,
  input  wire logic                 id_in_ready_i,
  output logic                      pop_o,
  output logic [if_pkg::XLEN-1:0]   pc_if_o,
  output if_pkg::id_instr_t         id_instr_o,
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o
);

  logic load;
  logic valid_d;
  logic valid_q;
  logic new_q;

  // word moves on only when decode can take it
  assign load    = fetch_valid_i & id_in_ready_i;
  assign pop_o   = load;
  assign pc_if_o = fetch_entry_i.addr;

  // a redirect squashes the word loaded in the same cycle
  // valid then sticks until decode clears it
  assign valid_d = (load & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  ////////////////////
  // flags
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= load;
    end
  end

  ////////////////////
  // payload
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (load) begin
      id_instr_o.rdata     <= fetch_entry_i.rdata;
      id_instr_o.pc        <= fetch_entry_i.addr;
      // pmp check applies to the address leaving the fifo now
      id_instr_o.fetch_err <= fetch_entry_i.err | pmp_err_if_i;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

`default_nettype wire

//--- src/if_stage.sv
////////////////////
// instruction fetch stage
// pc selection, prefetch buffer and if-id register
////////////////////

`default_nettype none

module if_stage (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,

  input  wire logic [if_pkg::XLEN-1:0] boot_addr_i,
  // fetch enable from the controller
  input  wire logic                    req_i,

  // instruction bus
  output logic                         instr_req_o,
  output logic [if_pkg::XLEN-1:0]      instr_addr_o,
  input  wire logic                    instr_gnt_i,
  input  wire logic                    instr_rvalid_i,
  input  wire logic [if_pkg::XLEN-1:0] instr_rdata_i,
  input  wire logic                    instr_bus_err_i,

  input  wire logic                    pmp_err_if_i,

  // redirect control
  input  wire logic                    pc_set_i,
  input  wire if_pkg::pc_sel_e         pc_mux_i,
  input  wire if_pkg::exc_pc_sel_e     exc_pc_mux_i,
  input  wire if_pkg::exc_cause_t      exc_cause_i,
  input  wire logic [if_pkg::XLEN-1:0] branch_target_ex_i,
  input  wire if_pkg::csr_pc_t         csr_pc_i,
  output logic                         csr_mtvec_init_o,

  // decode side
  input  wire logic                    instr_valid_clear_i,
  input  wire logic                    id_in_ready_i,
  output if_pkg::id_instr_t            id_instr_o,
  output logic                         instr_valid_id_o,
  output logic                         instr_new_id_o,
  output logic [if_pkg::XLEN-1:0]      pc_if_o,
  output logic                         if_busy_o
);

  // redirect into the prefetcher
  logic                    branch;
  logic [if_pkg::XLEN-1:0] branch_addr;

  // prefetcher to fifo
  logic                    push;
  if_pkg::fetch_entry_t    push_entry;
  logic [1:0]              fifo_count;

  // fifo to if-id register
  logic                    fetch_valid;
  if_pkg::fetch_entry_t    fetch_head;
  logic                    pop;

  ////////////////////
  // next pc
  ////////////////////
  pc_select i_pc_select (
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .exc_cause_i        (exc_cause_i),
    .boot_addr_i        (boot_addr_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_pc_i           (csr_pc_i),
    .branch_o           (branch),
    .branch_addr_o      (branch_addr),
    .csr_mtvec_init_o   (csr_mtvec_init_o)
  );

  ////////////////////
  // prefetch buffer
  ////////////////////
  prefetch_ctrl i_prefetch_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (branch),
    .branch_addr_i   (branch_addr),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i),
    .fifo_count_i    (fifo_count),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .push_o          (push),
    .push_entry_o    (push_entry),
    .busy_o          (if_busy_o)
  );

  // a redirect also empties the queue
  fetch_fifo i_fetch_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (branch),
    .push_i       (push),
    .push_entry_i (push_entry),
    .pop_i        (pop),
    .valid_o      (fetch_valid),
    .head_o       (fetch_head),
    .count_o      (fifo_count)
  );

  ////////////////////
  // if-id register
  ////////////////////
  if_id_regs i_if_id_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_entry_i       (fetch_head),
    .pmp_err_if_i        (pmp_err_if_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .id_in_ready_i       (id_in_ready_i),
    .pop_o               (pop),
    .pc_if_o             (pc_if_o),
    .id_instr_o          (id_instr_o),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
////////////////////
// testbench clock and reset
// free running clock, active low reset for the first cycles
////////////////////

`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned PERIOD     = 40;
  localparam int unsigned RST_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release on a rising edge, like every other driven input
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

//--- tb/tb_if_stage.sv
////////////////////
// fetch stage testbench
// directed tests against a memory model with random grant
// delays, in-order responses and an error window
////////////////////

`default_nettype none

module tb_if_stage;

  localparam int unsigned    CYCLES_PER_TEST = 200;
  localparam int unsigned    NUM_TESTS       = 6;
  localparam logic [31:0]    SEED            = 32'd68203;
  // words in this window answer with a bus error
  localparam logic [31:0]    ERR_LO          = 32'h0000_4000;
  localparam logic [31:0]    ERR_HI          = 32'h0000_400F;

  logic                        clk_i;
  logic                        rst_ni;
  logic [if_pkg::XLEN-1:0]     boot_addr_i;
  logic                        req_i;
  logic                        instr_req_o;
  logic [if_pkg::XLEN-1:0]     instr_addr_o;
  logic                        instr_gnt_i     = 1'b1;
  logic                        instr_rvalid_i  = 1'b0;
  logic [if_pkg::XLEN-1:0]     instr_rdata_i   = '0;
  logic                        instr_bus_err_i = 1'b0;
  logic                        pmp_err_if_i;
  logic                        pc_set_i;
  if_pkg::pc_sel_e             pc_mux_i;
  if_pkg::exc_pc_sel_e         exc_pc_mux_i;
  if_pkg::exc_cause_t          exc_cause_i;
  logic [if_pkg::XLEN-1:0]     branch_target_ex_i;
  if_pkg::csr_pc_t             csr_pc_i;
  logic                        csr_mtvec_init_o;
  logic                        instr_valid_clear_i;
  logic                        id_in_ready_i;
  if_pkg::id_instr_t           id_instr_o;
  logic                        instr_valid_id_o;
  logic                        instr_new_id_o;
  logic [if_pkg::XLEN-1:0]     pc_if_o;
  logic                        if_busy_o;

  // memory model state
  logic [if_pkg::XLEN-1:0]     rsp_q[$];
  logic [1:0]                  gnt_wait    = 2'd0;
  logic                        rsp_stall   = 1'b0;
  logic [31:0]                 gnt_lfsr    = SEED;
  logic [31:0]                 rdy_lfsr    = SEED;
  // words seen in decode, with the pmp level at their load
  if_pkg::id_instr_t           id_q[$];
  logic                        pmp_q[$];
  logic                        pmp_at_load = 1'b0;

  int unsigned                 check_count = 0;
  int unsigned                 error_count = 0;

  tb_clk_gen i_tb_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  if_stage i_if_stage (.*);

  ////////////////////
  // helpers
  ////////////////////

  // 32 bit fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic in_err_range(input logic [if_pkg::XLEN-1:0] a);
    return (a >= ERR_LO) && (a <= ERR_HI);
  endfunction

  function automatic logic [if_pkg::XLEN-1:0] word_align(input logic [if_pkg::XLEN-1:0] a);
    return {a[if_pkg::XLEN-1:2], 2'b00};
  endfunction

  task automatic check_addr(input string name, input logic [if_pkg::XLEN-1:0] exp,
                            input logic [if_pkg::XLEN-1:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_instr(input string name, input if_pkg::id_instr_t exp,
                             input if_pkg::id_instr_t act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("FAILED %s expected %b actual %b", name, exp, act);
    end
  endtask

  ////////////////////
  // memory model
  ////////////////////
  always @(posedge clk_i) begin : bus_responder
    logic [if_pkg::XLEN-1:0] rsp_addr;
    logic [1:0]              delay;
    // one in-order response per cycle, data is the inverted address
    if ((rsp_q.size() > 0) && !rsp_stall) begin
      rsp_addr = rsp_q.pop_front();
      instr_rvalid_i  <= 1'b1;
      instr_rdata_i   <= ~rsp_addr;
      instr_bus_err_i <= in_err_range(rsp_addr);
    end else begin
      instr_rvalid_i  <= 1'b0;
      instr_bus_err_i <= 1'b0;
    end
    if (instr_req_o && instr_gnt_i) begin
      rsp_q.push_back(instr_addr_o);
      // next grant comes 0 to 2 cycles after the request
      gnt_lfsr = lfsr_next(gnt_lfsr);
      delay[0] = gnt_lfsr[0];
      gnt_lfsr = lfsr_next(gnt_lfsr);
      delay[1] = gnt_lfsr[0];
      delay    = delay % 2'd3;
      gnt_wait    <= delay;
      instr_gnt_i <= (delay == 2'd0);
    end else if (instr_req_o && (gnt_wait != 2'd0)) begin
      gnt_wait    <= gnt_wait - 2'd1;
      instr_gnt_i <= (gnt_wait == 2'd1);
    end
  end

  // new flag marks the cycle after a load, pmp sampled at that load
  always @(posedge clk_i) begin : id_monitor
    if (instr_new_id_o) begin
      id_q.push_back(id_instr_o);
      pmp_q.push_back(pmp_at_load);
    end
    pmp_at_load = pmp_err_if_i;
  end

  ////////////////////
  // stimulus
  ////////////////////

  // pc_set for one cycle, then check the first request of the new stream
  task automatic redirect(input string name, input if_pkg::pc_sel_e sel,
                          input if_pkg::exc_pc_sel_e exc_sel,
                          input if_pkg::exc_cause_t cause, input logic exp_init,
                          input logic [if_pkg::XLEN-1:0] exp_addr);
    @(posedge clk_i);
    pc_set_i            <= 1'b1;
    pc_mux_i            <= sel;
    exc_pc_mux_i        <= exc_sel;
    exc_cause_i         <= cause;
    instr_valid_clear_i <= 1'b1;
    id_in_ready_i       <= 1'b0;
    @(negedge clk_i);
    check_flag({name, " mtvec init"}, exp_init, csr_mtvec_init_o);
    @(posedge clk_i);
    pc_set_i            <= 1'b0;
    instr_valid_clear_i <= 1'b0;
    id_in_ready_i       <= 1'b1;
    @(negedge clk_i);
    check_flag({name, " req"}, 1'b1, instr_req_o);
    check_addr({name, " addr"}, exp_addr, instr_addr_o);
    check_flag({name, " busy"}, 1'b1, if_busy_o);
    check_flag({name, " valid drop"}, 1'b0, instr_valid_id_o);
    // anything seen so far belongs to the old stream
    id_q.delete();
    pmp_q.delete();
  endtask

  task automatic wait_words(input int n);
    while (id_q.size() < n) @(posedge clk_i);
  endtask

  // words must be consecutive from start with the memory rule applied
  task automatic check_stream(input string name, input logic [if_pkg::XLEN-1:0] start,
                              input int n);
    if_pkg::id_instr_t exp;
    wait_words(n);
    for (int i = 0; i < n; i++) begin
      exp.pc        = start + (32'(i) << 2);
      exp.rdata     = ~exp.pc;
      exp.fetch_err = in_err_range(exp.pc) | pmp_q[i];
      check_instr($sformatf("%s word %0d", name, i), exp, id_q[i]);
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_boot();
    logic [if_pkg::XLEN-1:0] exp;
    exp = (boot_addr_i & 32'hFFFF_FF00) + 32'h80;
    redirect("boot", if_pkg::PC_BOOT, if_pkg::EXC_PC_EXC, '0, 1'b1, exp);
    check_stream("boot", exp, 6);
  endtask

  task automatic test_redirects();
    redirect("jump", if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, '0, 1'b0,
             word_align(branch_target_ex_i));
    check_stream("jump", word_align(branch_target_ex_i), 3);
    redirect("mret", if_pkg::PC_ERET, if_pkg::EXC_PC_EXC, '0, 1'b0,
             word_align(csr_pc_i.mepc));
    check_stream("mret", word_align(csr_pc_i.mepc), 3);
    redirect("dret", if_pkg::PC_DRET, if_pkg::EXC_PC_EXC, '0, 1'b0,
             word_align(csr_pc_i.depc));
    check_stream("dret", word_align(csr_pc_i.depc), 3);
  endtask

  task automatic test_vectors();
    logic [if_pkg::XLEN-1:0] base;
    if_pkg::exc_cause_t      ext;
    if_pkg::exc_cause_t      int_irq;
    base                = csr_pc_i.mtvec & 32'hFFFF_FF00;
    ext.irq_ext         = 1'b1;
    ext.irq_int         = 1'b0;
    ext.lower_cause     = 5'd5;
    int_irq.irq_ext     = 1'b0;
    int_irq.irq_int     = 1'b1;
    int_irq.lower_cause = 5'd3;
    redirect("exc", if_pkg::PC_EXC, if_pkg::EXC_PC_EXC, '0, 1'b0, base);
    check_stream("exc", base, 2);
    redirect("irq ext", if_pkg::PC_EXC, if_pkg::EXC_PC_IRQ, ext, 1'b0, base + 32'd20);
    check_stream("irq ext", base + 32'd20, 2);
    // internal interrupts land in slot 31
    redirect("irq int", if_pkg::PC_EXC, if_pkg::EXC_PC_IRQ, int_irq, 1'b0, base + 32'd124);
    check_stream("irq int", base + 32'd124, 2);
    redirect("dbg halt", if_pkg::PC_EXC, if_pkg::EXC_PC_DBD, '0, 1'b0, 32'h1A11_0800);
    check_stream("dbg halt", 32'h1A11_0800, 2);
    redirect("dbg exc", if_pkg::PC_EXC, if_pkg::EXC_PC_DBG_EXC, '0, 1'b0, 32'h1A11_0808);
    check_stream("dbg exc", 32'h1A11_0808, 2);
  endtask

  task automatic test_backpressure();
    redirect("stall", if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, '0, 1'b0,
             word_align(branch_target_ex_i));
    repeat (40) begin
      @(posedge clk_i);
      rdy_lfsr = lfsr_next(rdy_lfsr);
      id_in_ready_i <= rdy_lfsr[0];
    end
    // long stall, fifo fills and requests must stop
    @(posedge clk_i);
    id_in_ready_i <= 1'b0;
    repeat (10) @(posedge clk_i);
    repeat (4) begin
      @(negedge clk_i);
      check_flag("stall req", 1'b0, instr_req_o);
      check_flag("stall busy", 1'b0, if_busy_o);
      // fifo head is the word right after the one held in decode
      check_addr("stall pc_if", word_align(branch_target_ex_i) + (32'(id_q.size()) << 2),
                 pc_if_o);
    end
    @(posedge clk_i);
    id_in_ready_i <= 1'b1;
    check_stream("stall", word_align(branch_target_ex_i), 12);
  endtask

  task automatic test_errors();
    int pmp_words;
    pmp_words = 0;
    @(posedge clk_i);
    branch_target_ex_i <= 32'h0000_3FF8;
    redirect("bus err", if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, '0, 1'b0, 32'h0000_3FF8);
    check_stream("bus err", 32'h0000_3FF8, 8);
    @(posedge clk_i);
    branch_target_ex_i <= 32'h0000_5000;
    redirect("pmp err", if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, '0, 1'b0, 32'h0000_5000);
    wait_words(2);
    @(posedge clk_i);
    pmp_err_if_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    pmp_err_if_i <= 1'b0;
    check_stream("pmp err", 32'h0000_5000, 8);
    for (int i = 0; i < 8; i++) begin
      if (pmp_q[i]) pmp_words++;
    end
    if (pmp_words == 0) begin
      error_count++;
      $display("no word was loaded into decode while the pmp error was raised");
    end
  endtask

  task automatic test_flush();
    @(posedge clk_i);
    branch_target_ex_i <= 32'h0000_1234;
    redirect("old", if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, '0, 1'b0, 32'h0000_1234);
    wait_words(2);
    // hold responses back so the redirect leaves them in flight
    @(posedge clk_i);
    rsp_stall <= 1'b1;
    repeat (6) @(posedge clk_i);
    redirect("flush", if_pkg::PC_DRET, if_pkg::EXC_PC_EXC, '0, 1'b0,
             word_align(csr_pc_i.depc));
    @(posedge clk_i);
    rsp_stall <= 1'b0;
    check_stream("flush", word_align(csr_pc_i.depc), 4);
    // valid holds while decode stalls, clear drops it
    @(posedge clk_i);
    id_in_ready_i <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    check_flag("valid held", 1'b1, instr_valid_id_o);
    @(posedge clk_i);
    instr_valid_clear_i <= 1'b1;
    @(posedge clk_i);
    instr_valid_clear_i <= 1'b0;
    @(negedge clk_i);
    check_flag("valid clear", 1'b0, instr_valid_id_o);
    @(posedge clk_i);
    id_in_ready_i <= 1'b1;
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    boot_addr_i         = 32'h0000_0137;
    req_i               = 1'b0;
    pmp_err_if_i        = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = if_pkg::PC_BOOT;
    exc_pc_mux_i        = if_pkg::EXC_PC_EXC;
    exc_cause_i         = '0;
    branch_target_ex_i  = 32'h0000_1236;
    csr_pc_i.mepc       = 32'h0000_2239;
    csr_pc_i.depc       = 32'h0000_2F0B;
    csr_pc_i.mtvec      = 32'h0000_3A5D;
    instr_valid_clear_i = 1'b0;
    id_in_ready_i       = 1'b1;
    while (!rst_ni) @(posedge clk_i);
    // idle state straight out of reset
    @(negedge clk_i);
    check_flag("reset req", 1'b0, instr_req_o);
    check_flag("reset valid", 1'b0, instr_valid_id_o);
    check_flag("reset new", 1'b0, instr_new_id_o);
    check_flag("reset busy", 1'b0, if_busy_o);
    @(posedge clk_i);
    req_i <= 1'b1;
    test_boot();
    test_redirects();
    test_vectors();
    test_backpressure();
    test_errors();
    test_flush();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // bounded run time for all tests together
  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk_i);
    $display("timeout: tests did not finish within %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
common/if_pkg.sv
src/pc_select.sv
prefetch/fetch_fifo.sv
prefetch/prefetch_ctrl.sv
src/if_id_regs.sv
src/if_stage.sv
tb/tb_clk_gen.sv
tb/tb_if_stage.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_if_stage
RTL_TOP   = if_stage
FLIST     = flist.f
OBJ_DIR   = obj_dir

RTL_FILES = $(filter-out tb/%,$(shell cat $(FLIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)
